// ==== verilog/rv32i_types.sv ====
`default_nettype none

package rv32i_types;

    // major opcodes seen by the integer lanes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    // funct3 for base integer ops
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct3 for the M extension multiply forms
    localparam logic [2:0] F3_MUL     = 3'b000;
    localparam logic [2:0] F3_MULH    = 3'b001;
    localparam logic [2:0] F3_MULHSU  = 3'b010;
    localparam logic [2:0] F3_MULHU   = 3'b011;

    // funct7 encodings
    localparam logic [6:0] F7_BASE    = 7'b0000000;
    // sub and sra
    localparam logic [6:0] F7_ALT     = 7'b0100000;
    localparam logic [6:0] F7_MULDIV  = 7'b0000001;

    // one instruction word, decoded two ways
    typedef union packed {
        // register-register layout
        struct packed {
            logic [6:0]  funct7;
            logic [4:0]  rs2;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } r;
        // register-immediate layout, imm overlays funct7 and rs2
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
    } rv32i_instr_t;

endpackage : rv32i_types

`default_nettype wire

// ==== verilog/exec_pkg.sv ====
`default_nettype none

package exec_pkg;

    // datapath width
    localparam int XLEN = 32;

    // physical register count, index width follows from it
    localparam int DEFAULT_NUM_REGS = 64;

    // multiplier pipeline depth, never below 1
    localparam int DEFAULT_MUL_STAGES = 3;

endpackage : exec_pkg

`default_nettype wire

// ==== verilog/physical_regfile.sv ====
`timescale 1ns/100ps
`default_nettype none

module physical_regfile
import exec_pkg::*;
#(
    parameter int NUM_REGS = DEFAULT_NUM_REGS
) (
    input  logic                        clk,
    input  logic                        rst,
    // write ports, alu / mul / load return
    input  logic                        alu_we,
    input  logic [$clog2(NUM_REGS)-1:0] alu_rd,
    input  logic [XLEN-1:0]             alu_v,
    input  logic                        mul_we,
    input  logic [$clog2(NUM_REGS)-1:0] mul_rd,
    input  logic [XLEN-1:0]             mul_v,
    input  logic                        ldst_we,
    input  logic [$clog2(NUM_REGS)-1:0] ldst_rd,
    input  logic [XLEN-1:0]             ldst_v,
    // read index pairs
    input  logic [$clog2(NUM_REGS)-1:0] alu_rs1,
    input  logic [$clog2(NUM_REGS)-1:0] alu_rs2,
    input  logic [$clog2(NUM_REGS)-1:0] mul_rs1,
    input  logic [$clog2(NUM_REGS)-1:0] mul_rs2,
    input  logic [$clog2(NUM_REGS)-1:0] ldst_rs1,
    input  logic [$clog2(NUM_REGS)-1:0] ldst_rs2,
    // registered read values
    output logic [XLEN-1:0]             alu_rs1_v,
    output logic [XLEN-1:0]             alu_rs2_v,
    output logic [XLEN-1:0]             mul_rs1_v,
    output logic [XLEN-1:0]             mul_rs2_v,
    output logic [XLEN-1:0]             ldst_rs1_v,
    output logic [XLEN-1:0]             ldst_rs2_v
);

    localparam int IDX_W = $clog2(NUM_REGS);

    // storage array, entry 0 is never written
    logic [XLEN-1:0] data [NUM_REGS];

    // writes from all three lanes land at the same edge
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                data[i] <= '0;
            end
        end else begin
            if (alu_we && (alu_rd != '0)) begin
                data[alu_rd] <= alu_v;
            end
            if (mul_we && (mul_rd != '0)) begin
                data[mul_rd] <= mul_v;
            end
            if (ldst_we && (ldst_rd != '0)) begin
                data[ldst_rd] <= ldst_v;
            end
        end
    end

    // registered reads see contents before this edge's writes
    // x0 forced to zero
    always_ff @(posedge clk) begin
        alu_rs1_v  <= (alu_rs1 != '0)  ? data[alu_rs1]  : '0;
        alu_rs2_v  <= (alu_rs2 != '0)  ? data[alu_rs2]  : '0;
        mul_rs1_v  <= (mul_rs1 != '0)  ? data[mul_rs1]  : '0;
        mul_rs2_v  <= (mul_rs2 != '0)  ? data[mul_rs2]  : '0;
        ldst_rs1_v <= (ldst_rs1 != '0) ? data[ldst_rs1] : '0;
        ldst_rs2_v <= (ldst_rs2 != '0) ? data[ldst_rs2] : '0;
    end

    // rename hands each lane a distinct destination in any one cycle
    property p_no_shared_dest(logic we_a, logic [IDX_W-1:0] rd_a,
                              logic we_b, logic [IDX_W-1:0] rd_b);
        @(posedge clk) disable iff (rst)
        !(we_a && we_b && (rd_a == rd_b) && (rd_a != '0));
    endproperty

    a_alu_mul_dest: assert property (p_no_shared_dest(alu_we, alu_rd, mul_we, mul_rd))
        else $error("physical_regfile: alu and mul write p%0d together", alu_rd);
    a_alu_ld_dest: assert property (p_no_shared_dest(alu_we, alu_rd, ldst_we, ldst_rd))
        else $error("physical_regfile: alu and load write p%0d together", alu_rd);
    a_mul_ld_dest: assert property (p_no_shared_dest(mul_we, mul_rd, ldst_we, ldst_rd))
        else $error("physical_regfile: mul and load write p%0d together", mul_rd);

endmodule : physical_regfile

`default_nettype wire

// ==== verilog/alu_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu_unit
import rv32i_types::*;
import exec_pkg::*;
#(
    parameter int NUM_REGS = DEFAULT_NUM_REGS
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        issue,
    input  rv32i_instr_t                instr,
    input  logic [$clog2(NUM_REGS)-1:0] rd_p,
    // operands, one cycle after issue
    input  logic [XLEN-1:0]             rs1_v,
    input  logic [XLEN-1:0]             rs2_v,
    output logic                        wb_we,
    output logic [$clog2(NUM_REGS)-1:0] wb_rd,
    output logic [XLEN-1:0]             wb_value
);

    localparam int IDX_W = $clog2(NUM_REGS);
    localparam int SHW   = $clog2(XLEN);

    // issue info held to meet the operands
    logic               s1_valid;
    rv32i_instr_t       s1_instr;
    logic [IDX_W-1:0]   s1_rd;

    logic               is_imm;
    logic               do_sub;
    logic               do_sra;
    logic [XLEN-1:0]    op_b;
    logic [SHW-1:0]     shamt;
    logic [XLEN-1:0]    result;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= issue;
        end
    end

    always_ff @(posedge clk) begin
        s1_instr <= instr;
        s1_rd    <= rd_p;
    end

    // operand b is rs2 or the sign extended immediate
    always_comb begin
        is_imm = (s1_instr.r.opcode == OPC_OP_IMM);
        op_b   = is_imm ? {{(XLEN-12){s1_instr.i.imm[11]}}, s1_instr.i.imm} : rs2_v;
        // low five bits serve both shift forms
        shamt  = op_b[SHW-1:0];
        // addi has no subtract form
        do_sub = !is_imm && (s1_instr.r.funct7 == F7_ALT);
        // srai flagged by imm bit 10, sra by funct7
        do_sra = is_imm ? s1_instr.i.imm[10] : (s1_instr.r.funct7 == F7_ALT);
    end

    always_comb begin
        unique case (s1_instr.r.funct3)
            F3_ADD_SUB: result = do_sub ? (rs1_v - op_b) : (rs1_v + op_b);
            F3_SLL:     result = rs1_v << shamt;
            F3_SLT:     result = {{(XLEN-1){1'b0}}, $signed(rs1_v) < $signed(op_b)};
            F3_SLTU:    result = {{(XLEN-1){1'b0}}, rs1_v < op_b};
            F3_XOR:     result = rs1_v ^ op_b;
            F3_SRL_SRA: result = do_sra ? XLEN'($signed(rs1_v) >>> shamt) : (rs1_v >> shamt);
            F3_OR:      result = rs1_v | op_b;
            F3_AND:     result = rs1_v & op_b;
            default:    result = '0;
        endcase
    end

    // writeback register, goes to the file one edge later
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_we <= 1'b0;
        end else begin
            wb_we <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd    <= s1_rd;
        wb_value <= result;
    end

    // scheduler keeps M-extension work off this lane
    a_alu_legal: assert property (@(posedge clk) disable iff (rst)
        issue |-> (instr.r.opcode == OPC_OP_IMM) ||
                  ((instr.r.opcode == OPC_OP) && (instr.r.funct7 != F7_MULDIV)))
        else $error("alu_unit: illegal instruction %h issued", instr);

endmodule : alu_unit

`default_nettype wire

// ==== verilog/mul_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module mul_unit
import rv32i_types::*;
import exec_pkg::*;
#(
    parameter int NUM_REGS   = DEFAULT_NUM_REGS,
    parameter int MUL_STAGES = DEFAULT_MUL_STAGES
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        issue,
    input  rv32i_instr_t                instr,
    input  logic [$clog2(NUM_REGS)-1:0] rd_p,
    input  logic [XLEN-1:0]             rs1_v,
    input  logic [XLEN-1:0]             rs2_v,
    output logic                        wb_we,
    output logic [$clog2(NUM_REGS)-1:0] wb_rd,
    output logic [XLEN-1:0]             wb_value
);

    localparam int IDX_W = $clog2(NUM_REGS);
    localparam int PW    = 2 * XLEN;

    // issue aligned with the registered operands
    logic               s0_valid;
    logic [2:0]         s0_funct3;
    logic [IDX_W-1:0]   s0_rd;

    logic               a_signed;
    logic               b_signed;
    logic [XLEN:0]      op_a;
    logic [XLEN:0]      op_b;
    logic [PW-1:0]      prod;
    logic               hi_sel;

    // product pipeline, last entry drives writeback
    logic               pipe_valid [MUL_STAGES];
    logic [PW-1:0]      pipe_prod  [MUL_STAGES];
    logic [IDX_W-1:0]   pipe_rd    [MUL_STAGES];
    logic               pipe_hi    [MUL_STAGES];

    always_ff @(posedge clk) begin
        if (rst) begin
            s0_valid <= 1'b0;
        end else begin
            s0_valid <= issue;
        end
    end

    always_ff @(posedge clk) begin
        s0_funct3 <= instr.r.funct3;
        s0_rd     <= rd_p;
    end

    // 33-bit operands cover signed and unsigned forms with one signed multiply
    always_comb begin
        a_signed = (s0_funct3 == F3_MULH) || (s0_funct3 == F3_MULHSU);
        b_signed = (s0_funct3 == F3_MULH);
        hi_sel   = (s0_funct3 != F3_MUL);
        op_a     = {a_signed & rs1_v[XLEN-1], rs1_v};
        op_b     = {b_signed & rs2_v[XLEN-1], rs2_v};
        // low 64 bits of the extended product
        prod     = $signed(op_a) * $signed(op_b);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < MUL_STAGES; k++) begin
                pipe_valid[k] <= 1'b0;
            end
        end else begin
            pipe_valid[0] <= s0_valid;
            for (int k = 1; k < MUL_STAGES; k++) begin
                pipe_valid[k] <= pipe_valid[k-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        pipe_prod[0] <= prod;
        pipe_rd[0]   <= s0_rd;
        pipe_hi[0]   <= hi_sel;
        for (int k = 1; k < MUL_STAGES; k++) begin
            pipe_prod[k] <= pipe_prod[k-1];
            pipe_rd[k]   <= pipe_rd[k-1];
            pipe_hi[k]   <= pipe_hi[k-1];
        end
    end

    // word select at the tail
    assign wb_we    = pipe_valid[MUL_STAGES-1];
    assign wb_rd    = pipe_rd[MUL_STAGES-1];
    assign wb_value = pipe_hi[MUL_STAGES-1] ? pipe_prod[MUL_STAGES-1][PW-1:XLEN]
                                            : pipe_prod[MUL_STAGES-1][XLEN-1:0];

    // only the four multiply forms reach this lane
    a_mul_legal: assert property (@(posedge clk) disable iff (rst)
        issue |-> (instr.r.opcode == OPC_OP) && (instr.r.funct7 == F7_MULDIV) &&
                  !instr.r.funct3[2])
        else $error("mul_unit: illegal instruction %h issued", instr);

endmodule : mul_unit

`default_nettype wire

// ==== verilog/exec_cluster.sv ====
`timescale 1ns/100ps
`default_nettype none

module exec_cluster
import rv32i_types::*;
import exec_pkg::*;
#(
    parameter int NUM_REGS   = DEFAULT_NUM_REGS,
    parameter int MUL_STAGES = DEFAULT_MUL_STAGES
) (
    input  logic                        clk,
    input  logic                        rst,
    // alu lane issue
    input  logic                        alu_issue,
    input  rv32i_instr_t                alu_instr,
    input  logic [$clog2(NUM_REGS)-1:0] alu_rs1_p,
    input  logic [$clog2(NUM_REGS)-1:0] alu_rs2_p,
    input  logic [$clog2(NUM_REGS)-1:0] alu_rd_p,
    // multiply lane issue
    input  logic                        mul_issue,
    input  rv32i_instr_t                mul_instr,
    input  logic [$clog2(NUM_REGS)-1:0] mul_rs1_p,
    input  logic [$clog2(NUM_REGS)-1:0] mul_rs2_p,
    input  logic [$clog2(NUM_REGS)-1:0] mul_rd_p,
    // store read request
    input  logic                        st_issue,
    input  logic [$clog2(NUM_REGS)-1:0] st_rs1_p,
    input  logic [$clog2(NUM_REGS)-1:0] st_rs2_p,
    // load return
    input  logic                        load_we,
    input  logic [$clog2(NUM_REGS)-1:0] load_rd_p,
    input  logic [XLEN-1:0]             load_value,
    // writebacks, also visible outside
    output logic                        alu_wb_we,
    output logic [$clog2(NUM_REGS)-1:0] alu_wb_rd,
    output logic [XLEN-1:0]             alu_wb_value,
    output logic                        mul_wb_we,
    output logic [$clog2(NUM_REGS)-1:0] mul_wb_rd,
    output logic [XLEN-1:0]             mul_wb_value,
    // store operands, base then data
    output logic                        st_valid,
    output logic [XLEN-1:0]             st_addr_v,
    output logic [XLEN-1:0]             st_data_v
);

    // operand wires from the file to each lane
    logic [XLEN-1:0] alu_rs1_v;
    logic [XLEN-1:0] alu_rs2_v;
    logic [XLEN-1:0] mul_rs1_v;
    logic [XLEN-1:0] mul_rs2_v;

    // store operands come back one edge after the request
    always_ff @(posedge clk) begin
        if (rst) begin
            st_valid <= 1'b0;
        end else begin
            st_valid <= st_issue;
        end
    end

    // shared file, merges both lanes and the load return
    physical_regfile #(
        .NUM_REGS   (NUM_REGS)
    ) u_regfile (
        .clk        (clk),
        .rst        (rst),
        .alu_we     (alu_wb_we),
        .alu_rd     (alu_wb_rd),
        .alu_v      (alu_wb_value),
        .mul_we     (mul_wb_we),
        .mul_rd     (mul_wb_rd),
        .mul_v      (mul_wb_value),
        .ldst_we    (load_we),
        .ldst_rd    (load_rd_p),
        .ldst_v     (load_value),
        .alu_rs1    (alu_rs1_p),
        .alu_rs2    (alu_rs2_p),
        .mul_rs1    (mul_rs1_p),
        .mul_rs2    (mul_rs2_p),
        .ldst_rs1   (st_rs1_p),
        .ldst_rs2   (st_rs2_p),
        .alu_rs1_v  (alu_rs1_v),
        .alu_rs2_v  (alu_rs2_v),
        .mul_rs1_v  (mul_rs1_v),
        .mul_rs2_v  (mul_rs2_v),
        .ldst_rs1_v (st_addr_v),
        .ldst_rs2_v (st_data_v)
    );

    alu_unit #(
        .NUM_REGS   (NUM_REGS)
    ) u_alu (
        .clk        (clk),
        .rst        (rst),
        .issue      (alu_issue),
        .instr      (alu_instr),
        .rd_p       (alu_rd_p),
        .rs1_v      (alu_rs1_v),
        .rs2_v      (alu_rs2_v),
        .wb_we      (alu_wb_we),
        .wb_rd      (alu_wb_rd),
        .wb_value   (alu_wb_value)
    );

    mul_unit #(
        .NUM_REGS   (NUM_REGS),
        .MUL_STAGES (MUL_STAGES)
    ) u_mul (
        .clk        (clk),
        .rst        (rst),
        .issue      (mul_issue),
        .instr      (mul_instr),
        .rd_p       (mul_rd_p),
        .rs1_v      (mul_rs1_v),
        .rs2_v      (mul_rs2_v),
        .wb_we      (mul_wb_we),
        .wb_rd      (mul_wb_rd),
        .wb_value   (mul_wb_value)
    );

endmodule : exec_cluster

`default_nettype wire

// ==== verification/exec_model.svh ====
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// shadow of the physical file, written at the same edges as the DUT
logic [XLEN-1:0]  shadow [NUM_REGS];

// expected alu writebacks, destination, value and the edge they show at
logic [IDX_W-1:0] alu_q_rd  [$];
logic [XLEN-1:0]  alu_q_val [$];
int               alu_q_due [$];

// expected multiply writebacks
logic [IDX_W-1:0] mul_q_rd  [$];
logic [XLEN-1:0]  mul_q_val [$];
int               mul_q_due [$];

// expected store operands, base then data
logic [XLEN-1:0]  st_q_addr [$];
logic [XLEN-1:0]  st_q_data [$];
int               st_q_due  [$];

task automatic model_reset();
    for (int i = 0; i < NUM_REGS; i++) begin
        shadow[i] = '0;
    end
endtask

// p0 always reads as zero
function automatic logic [XLEN-1:0] shadow_read(input logic [IDX_W-1:0] idx);
    return (idx == '0) ? '0 : shadow[idx];
endfunction

// writes to p0 vanish
task automatic shadow_write(input logic [IDX_W-1:0] idx, input logic [XLEN-1:0] v);
    if (idx != '0) begin
        shadow[idx] = v;
    end
endtask

function automatic bit queues_empty();
    return (alu_q_due.size() == 0) && (mul_q_due.size() == 0) && (st_q_due.size() == 0);
endfunction

// RV32I OP / OP-IMM result
function automatic logic [XLEN-1:0] alu_expect(input rv32i_instr_t ins,
                                               input logic [XLEN-1:0] a,
                                               input logic [XLEN-1:0] rs2);
    logic              imm_form;
    logic              alt;
    logic [XLEN-1:0]   b;
    logic [4:0]        sh;
    logic [2*XLEN-1:0] wide;
    imm_form = (ins.i.opcode == OPC_OP_IMM);
    b        = imm_form ? {{(XLEN-12){ins.i.imm[11]}}, ins.i.imm} : rs2;
    // word bit 30, sub / sra / srai
    alt      = ins.r.funct7[5];
    sh       = b[4:0];
    // arithmetic shift as a logical shift of a sign-filled double word
    wide     = {{XLEN{alt & a[XLEN-1]}}, a} >> sh;
    case (ins.r.funct3)
        F3_ADD_SUB: return (alt && !imm_form) ? (a - b) : (a + b);
        F3_SLL:     return a << sh;
        F3_SLT:     return ($signed(a) < $signed(b)) ? XLEN'(1) : '0;
        F3_SLTU:    return (a < b) ? XLEN'(1) : '0;
        F3_XOR:     return a ^ b;
        F3_SRL_SRA: return wide[XLEN-1:0];
        F3_OR:      return a | b;
        F3_AND:     return a & b;
        default:    return '0;
    endcase
endfunction

// 64-bit product of the extended operands, then pick a word
function automatic logic [XLEN-1:0] mul_expect(input logic [2:0] f3,
                                               input logic [XLEN-1:0] a,
                                               input logic [XLEN-1:0] b);
    logic [2*XLEN-1:0] ea;
    logic [2*XLEN-1:0] eb;
    logic [2*XLEN-1:0] p;
    ea = {{XLEN{1'b0}}, a};
    eb = {{XLEN{1'b0}}, b};
    if ((f3 == F3_MULH) || (f3 == F3_MULHSU)) begin
        ea = {{XLEN{a[XLEN-1]}}, a};
    end
    if (f3 == F3_MULH) begin
        eb = {{XLEN{b[XLEN-1]}}, b};
    end
    p = ea * eb;
    return (f3 == F3_MUL) ? p[XLEN-1:0] : p[2*XLEN-1:XLEN];
endfunction

`endif

// ==== verification/exec_cluster_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module exec_cluster_tb
import rv32i_types::*;
import exec_pkg::*;
();

    localparam int NUM_REGS   = 64;
    localparam int MUL_STAGES = 3;
    localparam int IDX_W      = $clog2(NUM_REGS);
    // edges from the issue edge to the edge that sees the writeback
    localparam int ALU_SEEN   = 2;
    localparam int MUL_SEEN   = MUL_STAGES + 1;
    // ops per phase
    localparam int N_RESET_RD = NUM_REGS / 2;
    localparam int N_LOAD     = 200;
    localparam int N_ALU      = 400;
    localparam int N_MUL      = 200;
    localparam int N_ZERO     = 40;
    localparam int N_MIXED    = 2000;
    localparam int N_OPS      = N_RESET_RD + N_LOAD + N_ALU + N_MUL + N_ZERO + N_MIXED;
    localparam int TIMEOUT_CYCLES = N_OPS * 4 + 100;

    logic                clk;
    logic                rst;
    logic                alu_issue;
    rv32i_instr_t        alu_instr;
    logic [IDX_W-1:0]    alu_rs1_p;
    logic [IDX_W-1:0]    alu_rs2_p;
    logic [IDX_W-1:0]    alu_rd_p;
    logic                mul_issue;
    rv32i_instr_t        mul_instr;
    logic [IDX_W-1:0]    mul_rs1_p;
    logic [IDX_W-1:0]    mul_rs2_p;
    logic [IDX_W-1:0]    mul_rd_p;
    logic                st_issue;
    logic [IDX_W-1:0]    st_rs1_p;
    logic [IDX_W-1:0]    st_rs2_p;
    logic                load_we;
    logic [IDX_W-1:0]    load_rd_p;
    logic [XLEN-1:0]     load_value;
    logic                alu_wb_we;
    logic [IDX_W-1:0]    alu_wb_rd;
    logic [XLEN-1:0]     alu_wb_value;
    logic                mul_wb_we;
    logic [IDX_W-1:0]    mul_wb_rd;
    logic [XLEN-1:0]     mul_wb_value;
    logic                st_valid;
    logic [XLEN-1:0]     st_addr_v;
    logic [XLEN-1:0]     st_data_v;

    logic [31:0]         rng_state;
    int                  cyc;

    `include "exec_model.svh"

    exec_cluster #(
        .NUM_REGS   (NUM_REGS),
        .MUL_STAGES (MUL_STAGES)
    ) u_exec_cluster (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic logic [IDX_W-1:0] pick_src();
        return IDX_W'(next_random() % NUM_REGS);
    endfunction

    // alu owns p1..p31, mul p32..p47, loads p48..p63
    function automatic logic [IDX_W-1:0] alu_dest();
        logic [31:0] r;
        r = next_random();
        return (r[7:4] == 4'd0) ? '0 : IDX_W'(1 + (r % 31));
    endfunction

    function automatic logic [IDX_W-1:0] mul_dest();
        logic [31:0] r;
        r = next_random();
        return (r[7:4] == 4'd0) ? '0 : IDX_W'(32 + (r % 16));
    endfunction

    function automatic logic [IDX_W-1:0] load_dest();
        return IDX_W'(48 + (next_random() % 16));
    endfunction

    // random OP or OP-IMM word, rd/rs fields left as noise
    function automatic rv32i_instr_t make_alu_instr();
        rv32i_instr_t ins;
        logic [31:0]  r;
        ins = next_random();
        r   = next_random();
        if (r[0]) begin
            ins.r.opcode = OPC_OP;
            ins.r.funct3 = r[3:1];
            // only add/sub and srl/sra have an alternate form
            ins.r.funct7 = (r[4] && ((r[3:1] == F3_ADD_SUB) || (r[3:1] == F3_SRL_SRA)))
                           ? F7_ALT : F7_BASE;
        end else begin
            ins.i.opcode = OPC_OP_IMM;
            ins.i.funct3 = r[3:1];
            // shift immediates, upper bits fixed
            if (r[3:1] == F3_SLL) begin
                ins.i.imm[11:5] = F7_BASE;
            end else if (r[3:1] == F3_SRL_SRA) begin
                ins.i.imm[11:5] = r[4] ? F7_ALT : F7_BASE;
            end
        end
        return ins;
    endfunction

    function automatic rv32i_instr_t make_mul_instr();
        rv32i_instr_t ins;
        ins          = next_random();
        ins.r.opcode = OPC_OP;
        ins.r.funct7 = F7_MULDIV;
        // mul, mulh, mulhsu, mulhu
        ins.r.funct3 = {1'b0, ins.r.funct3[1:0]};
        return ins;
    endfunction

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("Simulation FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_wb(input string            lane,
                            input logic [IDX_W-1:0] rd_got,
                            input logic [XLEN-1:0]  v_got,
                            input logic [IDX_W-1:0] rd_exp,
                            input logic [XLEN-1:0]  v_exp);
        if ((rd_got !== rd_exp) || (v_got !== v_exp)) begin
            stop_on_error($sformatf("MISMATCH at %0t: %s writeback p%0d=%h, expected p%0d=%h",
                                    $time, lane, rd_got, v_got, rd_exp, v_exp));
        end
    endtask

    task automatic check_store(input logic [XLEN-1:0] addr_got,
                               input logic [XLEN-1:0] data_got,
                               input logic [XLEN-1:0] addr_exp,
                               input logic [XLEN-1:0] data_exp);
        if ((addr_got !== addr_exp) || (data_got !== data_exp)) begin
            stop_on_error($sformatf("MISMATCH at %0t: store operands %h/%h, expected %h/%h",
                                    $time, addr_got, data_got, addr_exp, data_exp));
        end
    endtask

    // strobe must rise exactly at the head's due edge
    task automatic check_timing(input string lane, input logic we, input int due [$]);
        if (we && (due.size() == 0)) begin
            stop_on_error({lane, " result appeared with nothing outstanding"});
        end else if (we && (due[0] != cyc)) begin
            stop_on_error($sformatf("%s result at cycle %0d, expected at cycle %0d",
                                    lane, cyc, due[0]));
        end else if ((we !== 1'b1) && (due.size() != 0) && (due[0] <= cyc)) begin
            stop_on_error({lane, " result missing at its cycle"});
        end
    endtask

    task automatic clear_strobes();
        alu_issue <= 1'b0;
        mul_issue <= 1'b0;
        st_issue  <= 1'b0;
        load_we   <= 1'b0;
    endtask

    task automatic drive_alu(input logic [IDX_W-1:0] rs1, rs2, rd);
        alu_issue <= 1'b1;
        alu_instr <= make_alu_instr();
        alu_rs1_p <= rs1;
        alu_rs2_p <= rs2;
        alu_rd_p  <= rd;
    endtask

    task automatic drive_mul(input logic [IDX_W-1:0] rs1, rs2, rd);
        mul_issue <= 1'b1;
        mul_instr <= make_mul_instr();
        mul_rs1_p <= rs1;
        mul_rs2_p <= rs2;
        mul_rd_p  <= rd;
    endtask

    task automatic drive_store(input logic [IDX_W-1:0] rs1, rs2);
        st_issue <= 1'b1;
        st_rs1_p <= rs1;
        st_rs2_p <= rs2;
    endtask

    task automatic drive_load(input logic [IDX_W-1:0] rd, input logic [XLEN-1:0] v);
        load_we    <= 1'b1;
        load_rd_p  <= rd;
        load_value <= v;
    endtask

    // stop issuing, then wait for every expected result
    task automatic wait_idle();
        @(posedge clk);
        clear_strobes();
        do begin
            @(negedge clk);
        end while (!queues_empty());
    endtask

    // model and checks, inputs and outputs as sampled at this edge
    always @(posedge clk) begin : monitor
        logic             alu_w;
        logic [IDX_W-1:0] alu_w_rd;
        logic [XLEN-1:0]  alu_w_v;
        logic             mul_w;
        logic [IDX_W-1:0] mul_w_rd;
        logic [XLEN-1:0]  mul_w_v;
        cyc   = cyc + 1;
        alu_w = 1'b0;
        mul_w = 1'b0;
        if (cyc > TIMEOUT_CYCLES) begin
            stop_on_error($sformatf("timeout after %0d cycles", TIMEOUT_CYCLES));
        end
        if (rst) begin
            model_reset();
        end else begin
            check_timing("alu", alu_wb_we, alu_q_due);
            if (alu_wb_we) begin
                check_wb("alu", alu_wb_rd, alu_wb_value, alu_q_rd[0], alu_q_val[0]);
                alu_w    = 1'b1;
                alu_w_rd = alu_q_rd.pop_front();
                alu_w_v  = alu_q_val.pop_front();
                void'(alu_q_due.pop_front());
            end
            check_timing("mul", mul_wb_we, mul_q_due);
            if (mul_wb_we) begin
                check_wb("mul", mul_wb_rd, mul_wb_value, mul_q_rd[0], mul_q_val[0]);
                mul_w    = 1'b1;
                mul_w_rd = mul_q_rd.pop_front();
                mul_w_v  = mul_q_val.pop_front();
                void'(mul_q_due.pop_front());
            end
            check_timing("store", st_valid, st_q_due);
            if (st_valid) begin
                check_store(st_addr_v, st_data_v, st_q_addr[0], st_q_data[0]);
                void'(st_q_addr.pop_front());
                void'(st_q_data.pop_front());
                void'(st_q_due.pop_front());
            end
            // reads see the file before this edge's writes
            if (alu_issue) begin
                alu_q_rd.push_back(alu_rd_p);
                alu_q_val.push_back(alu_expect(alu_instr, shadow_read(alu_rs1_p),
                                               shadow_read(alu_rs2_p)));
                alu_q_due.push_back(cyc + ALU_SEEN);
            end
            if (mul_issue) begin
                mul_q_rd.push_back(mul_rd_p);
                mul_q_val.push_back(mul_expect(mul_instr.r.funct3, shadow_read(mul_rs1_p),
                                               shadow_read(mul_rs2_p)));
                mul_q_due.push_back(cyc + MUL_SEEN);
            end
            if (st_issue) begin
                st_q_addr.push_back(shadow_read(st_rs1_p));
                st_q_data.push_back(shadow_read(st_rs2_p));
                st_q_due.push_back(cyc + 1);
            end
            // then this edge's writes, model values only
            if (alu_w) begin
                shadow_write(alu_w_rd, alu_w_v);
            end
            if (mul_w) begin
                shadow_write(mul_w_rd, mul_w_v);
            end
            if (load_we) begin
                shadow_write(load_rd_p, load_value);
            end
        end
    end

    initial begin
        logic [IDX_W-1:0] ld_rd;
        logic [31:0]      r;
        rng_state  = 32'h78c8;
        cyc        = 0;
        clk        = 1'b0;
        rst        = 1'b1;
        alu_issue  = 1'b0;
        alu_instr  = '0;
        alu_rs1_p  = '0;
        alu_rs2_p  = '0;
        alu_rd_p   = '0;
        mul_issue  = 1'b0;
        mul_instr  = '0;
        mul_rs1_p  = '0;
        mul_rs2_p  = '0;
        mul_rd_p   = '0;
        st_issue   = 1'b0;
        st_rs1_p   = '0;
        st_rs2_p   = '0;
        load_we    = 1'b0;
        load_rd_p  = '0;
        load_value = '0;

        // four reset edges, strobes must already be quiet
        repeat (3) @(posedge clk);
        @(negedge clk);
        if ((alu_wb_we !== 1'b0) || (mul_wb_we !== 1'b0) || (st_valid !== 1'b0)) begin
            stop_on_error("writeback or store strobe active while reset is held");
        end
        @(posedge clk);
        rst <= 1'b0;

        // whole file reads zero
        for (int i = 0; i < N_RESET_RD; i++) begin
            @(posedge clk);
            clear_strobes();
            drive_store(IDX_W'(2 * i), IDX_W'(2 * i + 1));
        end
        wait_idle();

        // loads, with a same-cycle read of the index being written
        for (int i = 0; i < N_LOAD; i++) begin
            @(posedge clk);
            clear_strobes();
            ld_rd = load_dest();
            drive_load(ld_rd, next_random());
            drive_store(ld_rd, load_dest());
        end
        wait_idle();

        // back to back alu ops
        for (int i = 0; i < N_ALU; i++) begin
            @(posedge clk);
            clear_strobes();
            drive_alu(pick_src(), pick_src(), alu_dest());
        end
        wait_idle();

        // back to back multiplies, several in flight
        for (int i = 0; i < N_MUL; i++) begin
            @(posedge clk);
            clear_strobes();
            drive_mul(pick_src(), pick_src(), mul_dest());
        end
        wait_idle();

        // p0 as destination on every lane and as a source
        for (int i = 0; i < N_ZERO; i++) begin
            @(posedge clk);
            clear_strobes();
            drive_alu('0, pick_src(), '0);
            drive_mul(pick_src(), '0, '0);
            drive_load('0, next_random());
            drive_store('0, (i % 2 == 0) ? '0 : pick_src());
        end
        wait_idle();

        // everything at once, results feed later sources
        for (int i = 0; i < N_MIXED; i++) begin
            @(posedge clk);
            clear_strobes();
            r = next_random();
            if (r[0]) begin
                drive_alu(pick_src(), pick_src(), alu_dest());
            end
            if (r[1]) begin
                drive_mul(pick_src(), pick_src(), mul_dest());
            end
            if (r[2]) begin
                drive_store(pick_src(), pick_src());
            end
            if (r[3]) begin
                drive_load(load_dest(), next_random());
            end
        end
        wait_idle();

        if (queues_empty()) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            stop_on_error("expected results left over at the end of the run");
        end
    end

endmodule : exec_cluster_tb

`default_nettype wire

// ==== filelist.f ====
+incdir+verification
verilog/rv32i_types.sv
verilog/exec_pkg.sv
verilog/physical_regfile.sv
verilog/alu_unit.sv
verilog/mul_unit.sv
verilog/exec_cluster.sv
verification/exec_cluster_tb.sv

// ==== Bender.yml ====
package:
  name: exec_cluster

sources:
  # design sources, packages first
  - target: any(rtl, test)
    files:
      - verilog/rv32i_types.sv
      - verilog/exec_pkg.sv
      - verilog/physical_regfile.sv
      - verilog/alu_unit.sv
      - verilog/mul_unit.sv
      - verilog/exec_cluster.sv

  # testbench, includes the reference model header
  - target: test
    include_dirs:
      - verification
    files:
      - verification/exec_cluster_tb.sv
